/* dv/memModels.sv */
`timescale 1ns/1ps

// instruction ROM, read combinationally by word
module instrRom #(
   parameter int WORDS = 256
) (
   input  riscvPkg::word_t addr,
   output riscvPkg::word_t data
);
   import riscvPkg::*;

   word_t mem [WORDS];  // loaded by the testbench

   assign data = mem[addr[$clog2(WORDS)+1:2]];

endmodule

// data RAM, combinational read, write on the rising edge
module dataRam #(
   parameter int WORDS = 256
) (
   input  logic            clk,
   input  logic            we,
   input  riscvPkg::word_t addr,
   input  riscvPkg::word_t wd,
   output riscvPkg::word_t rd
);
   import riscvPkg::*;

   word_t mem [WORDS];

   always @(posedge clk) begin
      if (we) begin
         mem[addr[$clog2(WORDS)+1:2]] <= wd;  // byte address, word aligned
      end
   end

   assign rd = mem[addr[$clog2(WORDS)+1:2]];

endmodule

/* dv/riscvSingleTb.sv */
`timescale 1ns/1ps

module riscvSingleTb;
   import riscvPkg::*;

   localparam int ROM_WORDS = 256;
   localparam int RAM_WORDS = 256;
   localparam int RUN_LIMIT = 2000;  // cycles per wait

   logic  clk, reset, pcReady;
   word_t instr, readData, pc, dataAddr, writeData;
   logic  memWrite, memStrobe;

   string testName;
   word_t prog [$];
   word_t expAddr [$];
   word_t expData [$];
   word_t storeAddr;
   word_t finalPc;
   int    expStores;
   int    storeCount;

   riscvSingle i_riscvSingle (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .pcReady   (pcReady),
      .pc        (pc),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWrite  (memWrite),
      .memStrobe (memStrobe)
   );

   instrRom #(.WORDS(ROM_WORDS)) i_instrRom (.addr(pc), .data(instr));

   dataRam #(.WORDS(RAM_WORDS)) i_dataRam (
      .clk  (clk),
      .we   (memWrite),
      .addr (dataAddr),
      .wd   (writeData),
      .rd   (readData)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic checkEqual(string label, word_t expected, word_t actual);
      if (expected !== actual) begin
         $display("Error: test %s, %s: expected %h, actual %h", testName, label, expected, actual);
         $display("Simulation failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // strobe follows the opcode; stores counted once per executed instruction
   always @(negedge clk) begin
      if (!reset) begin
         checkEqual("memStrobe",
                    word_t'(instr[6:0] == OP_LOAD || instr[6:0] == OP_STORE),
                    word_t'(memStrobe));
         if (memWrite && pcReady) begin
            storeCount++;
         end
      end
   end

   function automatic word_t rType(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                   logic [2:0] f3, regAddr_t rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic word_t iType(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                   regAddr_t rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t sType(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
   endfunction

   function automatic word_t bType(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1,
                                   logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic word_t jType(logic [20:0] imm, regAddr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   function automatic word_t uType(logic [19:0] imm, regAddr_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   // RV32I reference result by funct3 and the alt bit of sub and sra
   function automatic word_t aluRef(logic [2:0] f3, bit alt, word_t a, word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic bit branchTaken(logic [2:0] f3, word_t a, word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t fillWord(word_t index);
      return (index * 32'h9e3779b1) ^ 32'h5a5a0000;
   endfunction

   function automatic void emit(word_t w);
      prog.push_back(w);
   endfunction

   function automatic word_t pcNow();
      return word_t'(prog.size() * 4);
   endfunction

   task automatic newProgram(string name);
      testName = name;
      prog.delete();
      expAddr.delete();
      expData.delete();
      expStores = 0;
      storeAddr = 32'h100;
   endtask

   // lui + addi with the upper part rounded for the signed low half
   task automatic putConst(regAddr_t rd, word_t v);
      word_t upper;
      upper = (v + 32'h800) >> 12;
      emit(uType(upper[19:0], rd, OP_LUI));
      emit(iType(v[11:0], rd, 3'b000, rd, OP_IMM));
   endtask

   // skipped stores must leave the fill word in place
   task automatic putStore(regAddr_t rs2, word_t expected, bit executes);
      emit(sType(storeAddr[11:0], rs2, 5'd0));
      expAddr.push_back(storeAddr);
      expData.push_back(executes ? expected : fillWord(storeAddr >> 2));
      if (executes) begin
         expStores++;
      end
      storeAddr += 4;
   endtask

   task automatic finishProgram();
      finalPc = pcNow();
      emit(jType(21'd0, 5'd0));  // self-loop
   endtask

   task automatic startProgram();
      @(negedge clk);
      reset      = 1'b1;
      pcReady    = 1'b1;
      storeCount = 0;
      for (int i = 0; i < ROM_WORDS; i++) begin
         // unused words get an undefined opcode
         i_instrRom.mem[i] = (i < prog.size()) ? prog[i] : ((word_t'(i) << 7) | 32'h7f);
      end
      for (int i = 0; i < RAM_WORDS; i++) begin
         i_dataRam.mem[i] = fillWord(i);
      end
      repeat (3) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic waitForPc(word_t target);
      int cycles;
      cycles = 0;
      while (pc !== target && cycles < RUN_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (pc !== target) begin
         $display("Timeout in test %s: pc did not reach %h within %0d cycles",
                  testName, target, RUN_LIMIT);
         $display("Simulation failed");
         $fatal(1, "pc wait timed out");
      end
   endtask

   task automatic checkMemory();
      for (int i = 0; i < expAddr.size(); i++) begin
         checkEqual($sformatf("word at %h", expAddr[i]), expData[i],
                    i_dataRam.mem[expAddr[i] >> 2]);
      end
      checkEqual("store count", expStores, storeCount);
      $display("%s: %0d stores seen, %0d words checked", testName, storeCount, expAddr.size());
   endtask

   task automatic runProgram();
      startProgram();
      waitForPc(finalPc);
      checkMemory();
   endtask

   task automatic aluCase(bit useImm, logic [2:0] f3, bit alt, word_t a, word_t b);
      logic [11:0] imm12;
      word_t       operandB;
      if (useImm) begin
         imm12 = 12'($urandom);
         if (f3 == 3'd1 || f3 == 3'd5) begin
            imm12 = {1'b0, alt, 5'b0, imm12[4:0]};  // shamt form
         end
         operandB = {{20{imm12[11]}}, imm12};
         emit(iType(imm12, 5'd1, f3, 5'd3, OP_IMM));
      end else begin
         operandB = b;
         emit(rType(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
      end
      putStore(5'd3, aluRef(f3, alt, a, operandB), 1'b1);
   endtask

   task automatic aluTest();
      word_t a, b;
      a = $urandom;
      b = $urandom;
      newProgram("alu");
      putConst(5'd1, a);
      putConst(5'd2, b);
      for (int f = 0; f < 8; f++) begin
         aluCase(1'b0, 3'(f), 1'b0, a, b);
      end
      aluCase(1'b0, 3'd0, 1'b1, a, b);  // sub
      aluCase(1'b0, 3'd5, 1'b1, a, b);  // sra
      for (int f = 0; f < 8; f++) begin
         aluCase(1'b1, 3'(f), 1'b0, a, b);
      end
      aluCase(1'b1, 3'd5, 1'b1, a, b);  // srai
      finishProgram();
      runProgram();
   endtask

   task automatic upperTest();
      word_t u1, u2, v, p, loadAddr;
      u1 = $urandom;
      u2 = $urandom;
      v  = $urandom;
      newProgram("upper and load/store");
      emit(uType(u1[19:0], 5'd3, OP_LUI));
      putStore(5'd3, {u1[19:0], 12'h000}, 1'b1);
      p = pcNow();
      emit(uType(u2[19:0], 5'd4, OP_AUIPC));
      putStore(5'd4, p + {u2[19:0], 12'h000}, 1'b1);
      putConst(5'd5, v);
      loadAddr = storeAddr;
      putStore(5'd5, v, 1'b1);
      emit(iType(12'(loadAddr - 8), 5'd0, 3'b000, 5'd6, OP_IMM));
      emit(iType(12'd8, 5'd6, 3'b010, 5'd7, OP_LOAD));  // lw x7, 8(x6)
      putStore(5'd7, v, 1'b1);
      finishProgram();
      runProgram();
   endtask

   task automatic branchTest();
      logic [2:0] conds [6];
      word_t      a, b, marker;
      conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      newProgram("branch");
      marker = $urandom;
      putConst(5'd5, marker);
      foreach (conds[i]) begin
         for (int pair = 0; pair < 2; pair++) begin
            a = $urandom;
            b = (pair == 1) ? a : $urandom;  // second pass uses equal operands
            putConst(5'd1, a);
            putConst(5'd2, b);
            emit(bType(13'd8, 5'd2, 5'd1, conds[i]));
            putStore(5'd5, marker, !branchTaken(conds[i], a, b));
         end
      end
      finishProgram();
      runProgram();
   endtask

   task automatic jumpTest();
      word_t marker, p, q;
      newProgram("jump");
      marker = $urandom;
      putConst(5'd6, marker);
      p = pcNow();
      emit(jType(21'd8, 5'd1));
      putStore(5'd6, marker, 1'b0);
      putStore(5'd1, p + 4, 1'b1);
      q = pcNow() + 4;  // address of the jalr
      emit(iType(12'(q + 4), 5'd0, 3'b000, 5'd7, OP_IMM));
      emit(iType(12'd5, 5'd7, 3'b000, 5'd2, OP_JALR));  // odd sum loses bit 0
      putStore(5'd6, marker, 1'b0);
      putStore(5'd2, q + 4, 1'b1);
      emit(jType(21'd8, 5'd0));
      putStore(5'd6, marker, 1'b0);
      emit(iType(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));
      emit(uType(20'($urandom), 5'd0, OP_LUI));
      putStore(5'd0, 32'd0, 1'b1);
      finishProgram();
      runProgram();
   endtask

   task automatic stallTest();
      word_t a, b, stallAt;
      int    stallLen;
      a = $urandom;
      b = $urandom;
      newProgram("stall");
      putConst(5'd1, a);
      putConst(5'd2, b);
      emit(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
      stallAt = pcNow();
      emit(rType(7'h00, 5'd2, 5'd1, 3'd4, 5'd4));
      emit(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd5));
      emit(rType(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
      emit(rType(7'h00, 5'd2, 5'd1, 3'd7, 5'd7));
      putStore(5'd3, aluRef(3'd0, 1'b0, a, b), 1'b1);
      putStore(5'd4, aluRef(3'd4, 1'b0, a, b), 1'b1);
      putStore(5'd5, aluRef(3'd0, 1'b1, a, b), 1'b1);
      putStore(5'd6, aluRef(3'd6, 1'b0, a, b), 1'b1);
      putStore(5'd7, aluRef(3'd7, 1'b0, a, b), 1'b1);
      finishProgram();
      runProgram();
      startProgram();
      waitForPc(stallAt);
      pcReady  = 1'b0;
      stallLen = $urandom_range(9, 2);
      repeat (stallLen) begin
         @(negedge clk);
         checkEqual("pc held", stallAt, pc);
      end
      pcReady = 1'b1;
      for (int k = 1; k <= 3; k++) begin
         @(negedge clk);
         checkEqual("pc step", stallAt + word_t'(4 * k), pc);
      end
      waitForPc(finalPc);
      checkMemory();
   endtask

   initial begin
      reset    = 1'b1;
      pcReady  = 1'b1;
      testName = "startup";
      void'($urandom(35));
      aluTest();
      upperTest();
      branchTest();
      jumpTest();
      stallTest();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* riscvSingle.f */
rtl/riscvPkg.sv
rtl/alu.sv
rtl/immExtend.sv
rtl/registerFile.sv
rtl/programCounter.sv
rtl/instrDecoder.sv
rtl/riscvSingle.sv
dv/memModels.sv
dv/riscvSingleTb.sv

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
   input  riscvPkg::word_t     a,
   input  riscvPkg::word_t     b,
   input  riscvPkg::aluOp_t    aluOp,
   output riscvPkg::word_t     result,
   output riscvPkg::aluFlags_t flags
);
   import riscvPkg::*;

   logic  subtract;
   word_t bOperand;
   word_t sum;

   // one adder for add, sub and the branch zero flag
   assign subtract = (aluOp == ALU_SUB);
   assign bOperand = subtract ? ~b : b;
   assign sum      = a + bOperand + {{(XLEN-1){1'b0}}, subtract};

   assign flags.zero         = (sum == '0);  // valid when subtracting
   assign flags.lessSigned   = $signed(a) < $signed(b);
   assign flags.lessUnsigned = a < b;

   always_comb begin
      case (aluOp)
         ALU_ADD,
         ALU_SUB:   result = sum;
         ALU_AND:   result = a & b;
         ALU_OR:    result = a | b;
         ALU_XOR:   result = a ^ b;
         ALU_SLT:   result = {{(XLEN-1){1'b0}}, flags.lessSigned};
         ALU_SLTU:  result = {{(XLEN-1){1'b0}}, flags.lessUnsigned};
         ALU_SLL:   result = a << b[4:0];
         ALU_SRL:   result = a >> b[4:0];
         ALU_SRA:   result = $signed(a) >>> b[4:0];  // keeps sign
         ALU_PASSB: result = b;
         default:   result = sum;
      endcase
   end

endmodule

/* rtl/immExtend.sv */
`timescale 1ns/1ps

module immExtend (
   input  riscvPkg::word_t   instr,
   input  riscvPkg::immFmt_t immFmt,
   output riscvPkg::word_t   imm
);
   import riscvPkg::*;

   always_comb begin
      case (immFmt)
         IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
         IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         IMM_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         IMM_J: begin
            imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         IMM_U:   imm = {instr[31:12], 12'b0};
         default: imm = '0;
      endcase
   end

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
   input  riscvPkg::word_t     instr,
   input  riscvPkg::aluFlags_t flags,
   output riscvPkg::ctrl_t     ctrl,
   output riscvPkg::pcSel_t    pcSel
);
   import riscvPkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7b5;
   aluOp_t     funcOp;
   logic       taken;

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign funct7b5 = instr[30];

   // ALU decode for R-type and I-type arithmetic
   always_comb begin
      case (funct3)
         3'b000:  funcOp = (opcode == OP_REG && funct7b5) ? ALU_SUB : ALU_ADD;
         3'b001:  funcOp = ALU_SLL;
         3'b010:  funcOp = ALU_SLT;
         3'b011:  funcOp = ALU_SLTU;
         3'b100:  funcOp = ALU_XOR;
         3'b101:  funcOp = funct7b5 ? ALU_SRA : ALU_SRL;  // srai also sets bit 30
         3'b110:  funcOp = ALU_OR;
         default: funcOp = ALU_AND;
      endcase
   end

   // main decoder; anything unknown leaves every field inactive
   always_comb begin
      ctrl = '0;
      case (opcode)
         OP_REG: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = funcOp;
         end
         OP_IMM: begin
            ctrl.regWrite     = 1'b1;
            ctrl.aluSrcBisImm = 1'b1;
            ctrl.aluOp        = funcOp;
         end
         OP_LOAD: begin
            ctrl.regWrite     = 1'b1;
            ctrl.memStrobe    = 1'b1;
            ctrl.aluSrcBisImm = 1'b1;
            ctrl.resultSrc    = RES_MEM;
         end
         OP_STORE: begin
            ctrl.memWrite     = 1'b1;
            ctrl.memStrobe    = 1'b1;
            ctrl.immFmt       = IMM_S;
            ctrl.aluSrcBisImm = 1'b1;
         end
         OP_BRANCH: begin
            ctrl.immFmt   = IMM_B;
            ctrl.aluOp    = ALU_SUB;  // flags compare rs1 with rs2
            ctrl.isBranch = 1'b1;
         end
         OP_JAL: begin
            ctrl.regWrite  = 1'b1;
            ctrl.immFmt    = IMM_J;
            ctrl.resultSrc = RES_PCPLUS4;
            ctrl.isJal     = 1'b1;
         end
         OP_JALR: begin
            ctrl.regWrite     = 1'b1;
            ctrl.aluSrcBisImm = 1'b1;
            ctrl.resultSrc    = RES_PCPLUS4;
            ctrl.isJalr       = 1'b1;
         end
         OP_LUI: begin
            ctrl.regWrite     = 1'b1;
            ctrl.immFmt       = IMM_U;
            ctrl.aluSrcBisImm = 1'b1;
            ctrl.aluOp        = ALU_PASSB;
         end
         OP_AUIPC: begin
            ctrl.regWrite     = 1'b1;
            ctrl.immFmt       = IMM_U;
            ctrl.aluSrcAisPc  = 1'b1;
            ctrl.aluSrcBisImm = 1'b1;
         end
         default: ;
      endcase
   end

   always_comb begin
      case (funct3)
         3'b000:  taken = flags.zero;           // beq
         3'b001:  taken = ~flags.zero;          // bne
         3'b100:  taken = flags.lessSigned;     // blt
         3'b101:  taken = ~flags.lessSigned;    // bge
         3'b110:  taken = flags.lessUnsigned;   // bltu
         3'b111:  taken = ~flags.lessUnsigned;  // bgeu
         default: taken = 1'b0;
      endcase
   end

   assign pcSel = ctrl.isJalr ? PC_JALR :
                  (ctrl.isJal || (ctrl.isBranch && taken)) ? PC_TARGET : PC_PLUS4;

endmodule

/* rtl/programCounter.sv */
`timescale 1ns/1ps

module programCounter (
   input  logic             clk,
   input  logic             reset,
   input  logic             pcReady,
   input  riscvPkg::pcSel_t pcSel,
   input  riscvPkg::word_t  imm,
   input  riscvPkg::word_t  jalrTarget,
   output riscvPkg::word_t  pc,
   output riscvPkg::word_t  pcPlus4
);
   import riscvPkg::*;

   word_t pcTarget;
   word_t pcNext;

   assign pcPlus4  = pc + 32'd4;
   assign pcTarget = pc + imm;  // branch and jal

   always_comb begin
      case (pcSel)
         PC_TARGET: pcNext = pcTarget;
         PC_JALR:   pcNext = {jalrTarget[XLEN-1:1], 1'b0};
         default:   pcNext = pcPlus4;
      endcase
   end

   // holds while pcReady is low
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= '0;
      end else if (pcReady) begin
         pc <= pcNext;
      end
   end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
   input  logic               clk,
   input  logic               we,
   input  riscvPkg::regAddr_t rs1,
   input  riscvPkg::regAddr_t rs2,
   input  riscvPkg::regAddr_t rd,
   input  riscvPkg::word_t    wd,
   output riscvPkg::word_t    rd1,
   output riscvPkg::word_t    rd2
);
   import riscvPkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (we && rd != '0) begin  // x0 never written
         regs[rd] <= wd;
      end
   end

   assign rd1 = (rs1 != '0) ? regs[rs1] : '0;
   assign rd2 = (rs2 != '0) ? regs[rs2] : '0;

endmodule

/* rtl/riscvPkg.sv */
package riscvPkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 1 << REG_ADDR_W;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] regAddr_t;

   // major opcodes, instr[6:0]
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASSB  // lui
   } aluOp_t;

   typedef enum logic [2:0] {
      IMM_I,
      IMM_S,
      IMM_B,
      IMM_J,
      IMM_U
   } immFmt_t;

   typedef enum logic [1:0] {
      RES_ALU,
      RES_MEM,
      RES_PCPLUS4  // link value for jal/jalr
   } resultSrc_t;

   typedef enum logic [1:0] {
      PC_PLUS4,
      PC_TARGET,  // pc + imm
      PC_JALR     // alu result, bit 0 cleared
   } pcSel_t;

   typedef struct packed {
      logic       regWrite;
      logic       memWrite;
      logic       memStrobe;
      immFmt_t    immFmt;
      logic       aluSrcAisPc;
      logic       aluSrcBisImm;
      aluOp_t     aluOp;
      resultSrc_t resultSrc;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
   } ctrl_t;

   typedef struct packed {
      logic zero;          // a - b == 0
      logic lessSigned;
      logic lessUnsigned;
   } aluFlags_t;

endpackage

/* rtl/riscvSingle.sv */
`timescale 1ns/1ps

module riscvSingle (
   input  logic            clk,
   input  logic            reset,
   input  riscvPkg::word_t instr,
   input  riscvPkg::word_t readData,
   input  logic            pcReady,
   output riscvPkg::word_t pc,
   output riscvPkg::word_t dataAddr,
   output riscvPkg::word_t writeData,
   output logic            memWrite,
   output logic            memStrobe
);
   import riscvPkg::*;

   ctrl_t     ctrl;
   pcSel_t    pcSel;
   aluFlags_t flags;
   word_t     pcPlus4;
   word_t     imm;
   word_t     rd1, rd2;
   word_t     srcA, srcB;
   word_t     aluResult;
   word_t     result;

   instrDecoder i_instrDecoder (
      .instr (instr),
      .flags (flags),
      .ctrl  (ctrl),
      .pcSel (pcSel)
   );

   programCounter i_programCounter (
      .clk        (clk),
      .reset      (reset),
      .pcReady    (pcReady),
      .pcSel      (pcSel),
      .imm        (imm),
      .jalrTarget (aluResult),
      .pc         (pc),
      .pcPlus4    (pcPlus4)
   );

   registerFile i_registerFile (
      .clk (clk),
      .we  (ctrl.regWrite),
      .rs1 (instr[19:15]),
      .rs2 (instr[24:20]),
      .rd  (instr[11:7]),
      .wd  (result),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   immExtend i_immExtend (
      .instr  (instr),
      .immFmt (ctrl.immFmt),
      .imm    (imm)
   );

   assign srcA = ctrl.aluSrcAisPc ? pc : rd1;  // auipc takes pc
   assign srcB = ctrl.aluSrcBisImm ? imm : rd2;

   alu i_alu (
      .a      (srcA),
      .b      (srcB),
      .aluOp  (ctrl.aluOp),
      .result (aluResult),
      .flags  (flags)
   );

   // write-back select
   always_comb begin
      case (ctrl.resultSrc)
         RES_MEM:     result = readData;
         RES_PCPLUS4: result = pcPlus4;
         default:     result = aluResult;
      endcase
   end

   assign dataAddr  = aluResult;
   assign writeData = rd2;  // sw only, full word
   assign memWrite  = ctrl.memWrite;
   assign memStrobe = ctrl.memStrobe;

endmodule
